//--- rtl/intr_test_pkg.sv
// Constants and types shared by the interrupt test function
// Covers the global register map, MMIO addressing and host write user fields
// Each RTL file pulls these in with a wildcard import in its module header
package intr_test_pkg;

    // ==================================================
    // Global register file
    // ==================================================

    // Number of 64-bit global registers behind the MMIO window
    localparam int NUM_CSRS = 8;

    typedef logic [2:0]  t_csr_idx;
    typedef logic [63:0] t_csr_data;
    typedef logic [15:0] t_mmio_addr;

    // Registers are 8 bytes wide so the index starts at byte address bit 3
    localparam int CSR_ADDR_LSB = 3;

    // Register map
    localparam t_csr_idx CSR_TEST_ID_LO = 3'd0;
    localparam t_csr_idx CSR_TEST_ID_HI = 3'd1;
    localparam t_csr_idx CSR_CONFIG     = 3'd2;
    localparam t_csr_idx CSR_STATUS     = 3'd3;

    // Software starts an interrupt sequence by writing register 0
    localparam t_csr_idx CSR_START = CSR_TEST_ID_LO;

    // Fixed identifier that software checks before running the test
    localparam logic [127:0] TEST_ID = 128'h3c9e51a7_d24b_4f08_9a61_e0b72c5d8f13;

    // Engine count reported in the low byte of the config register
    localparam logic [7:0] CFG_NUM_ENGINES = 8'd1;

    // ==================================================
    // Host write channel
    // ==================================================

    typedef logic [47:0] t_host_addr;
    typedef logic [15:0] t_host_user;

    // Marks a host write as an interrupt request instead of a memory write
    localparam int HOST_UFLAG_INTERRUPT = 0;

    // The interrupt index rides in the user field from this bit upward
    // and comes back unchanged with the response
    localparam int HOST_UFLAG_TAG_LSB = 8;

    // Largest legal NUM_INTR_IDS, also the width of the status mask field
    localparam int MAX_INTR_IDS = 16;

    // Width of an interrupt index for a given number of ids
    // A single id still needs one bit to form a legal vector
    function automatic int intr_id_width(input int num_ids);
        return (num_ids > 1) ? $clog2(num_ids) : 1;
    endfunction

endpackage

//--- rtl/engine_csr_if.sv
// Register access path between the MMIO CSR manager and the register owner
// The manager drives single-cycle write strobes with index and data
// The owner presents every register value at all times on rd_data
interface engine_csr_if
    import intr_test_pkg::*;
    ();

    // One-cycle write strobe, index and data are valid only with it
    logic      wr_req;
    t_csr_idx  wr_idx;
    t_csr_data wr_data;

    // Current value of each register, driven combinationally by the owner
    t_csr_data rd_data [NUM_CSRS];

    // Side that decodes MMIO traffic
    modport mgr
    (
        output wr_req,
        output wr_idx,
        output wr_data,
        input  rd_data
    );

    // Side that holds the registers
    modport owner
    (
        input  wr_req,
        input  wr_idx,
        input  wr_data,
        output rd_data
    );

endinterface

//--- rtl/mmio_csr_mgr.sv
// MMIO front end for the global registers
// Turns MMIO write strobes into one-cycle register writes on the CSR interface
// and answers MMIO reads one cycle after the strobe with the selected register
// Addresses beyond the register window are dropped on write and read as zero
module mmio_csr_mgr
    import intr_test_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,

    // MMIO write channel
    input  logic       mmio_wr_valid,
    input  t_mmio_addr mmio_wr_addr,
    input  t_csr_data  mmio_wr_data,

    // MMIO read channel
    input  logic       mmio_rd_valid,
    input  t_mmio_addr mmio_rd_addr,
    output logic       mmio_rd_data_valid,
    output t_csr_data  mmio_rd_data,

    // Register owner
    engine_csr_if.mgr  csr
);

    // Size of the register window in bytes
    localparam t_mmio_addr CSR_SPACE_BYTES = t_mmio_addr'(NUM_CSRS << CSR_ADDR_LSB);

    logic      wr_in_range;
    t_csr_idx  wr_idx_dec;
    logic      rd_in_range;
    t_csr_idx  rd_idx_dec;
    t_csr_data rd_sel;

    // ==================================================
    // Address decode
    // ==================================================

    // Byte address divided by the register width gives the index
    assign wr_in_range = (mmio_wr_addr < CSR_SPACE_BYTES);
    assign wr_idx_dec  = mmio_wr_addr[CSR_ADDR_LSB +: $bits(t_csr_idx)];

    assign rd_in_range = (mmio_rd_addr < CSR_SPACE_BYTES);
    assign rd_idx_dec  = mmio_rd_addr[CSR_ADDR_LSB +: $bits(t_csr_idx)];

    // ==================================================
    // Write path
    // ==================================================

    // The strobe is registered so the owner sees it one cycle after MMIO
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            csr.wr_req <= 1'b0;
        end
        else
        begin
            csr.wr_req <= mmio_wr_valid && wr_in_range;
        end
    end

    // Index and data only matter in the cycle wr_req is high
    always_ff @(posedge clk)
    begin
        if (mmio_wr_valid)
        begin
            csr.wr_idx  <= wr_idx_dec;
            csr.wr_data <= mmio_wr_data;
        end
    end

    // ==================================================
    // Read path
    // ==================================================

    // Pick the register in the strobe cycle so the answer reflects that cycle
    always_comb
    begin
        rd_sel = '0;
        if (rd_in_range)
        begin
            rd_sel = csr.rd_data[rd_idx_dec];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            mmio_rd_data_valid <= 1'b0;
        end
        else
        begin
            mmio_rd_data_valid <= mmio_rd_valid;
        end
    end

    // Read data is held until the next read
    always_ff @(posedge clk)
    begin
        if (mmio_rd_valid)
        begin
            mmio_rd_data <= rd_sel;
        end
    end

endmodule

//--- rtl/intr_engine.sv
// Interrupt sequencing engine and owner of the global registers
// A write to register 0 sets the highest interrupt index and starts issue
// One request goes out per cycle from index 0 up to that maximum
// Responses are counted and their indices recorded in a mask for the status
// register, so returns in any order are accounted for
module intr_engine
    import intr_test_pkg::*;
#(
    parameter  int NUM_INTR_IDS = 4,
    localparam int ID_W         = intr_id_width(NUM_INTR_IDS)
)
(
    input  logic            clk,
    input  logic            reset_n,

    // Register access from the CSR manager
    engine_csr_if.owner     csr,

    // Interrupt requests toward the host shim
    output logic            intr_req_valid,
    output logic [ID_W-1:0] intr_req_id,

    // Decoded responses from the host shim
    input  logic            intr_rsp_valid,
    input  logic [ID_W-1:0] intr_rsp_id
);

    typedef logic [ID_W-1:0] t_intr_id;

    logic                    start_cmd;
    t_intr_id                start_max;
    logic                    state_active;
    t_intr_id                cur_id;
    t_intr_id                max_id;
    logic [7:0]              rsp_count;
    logic [NUM_INTR_IDS-1:0] rsp_mask;
    logic [MAX_INTR_IDS-1:0] status_mask;

    // ==================================================
    // Issue sequencing
    // ==================================================

    assign start_cmd = csr.wr_req && (csr.wr_idx == CSR_START);

    // Requested maximum folded into the legal id range
    assign start_max = t_intr_id'(32'(csr.wr_data[ID_W-1:0]) % NUM_INTR_IDS);

    // Id 0 goes out in the start cycle itself
    // The FSM then walks from id 1 up to the maximum
    // A start during an active sequence restarts it from id 0
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state_active <= 1'b0;
            cur_id       <= '0;
            max_id       <= '0;
        end
        else if (start_cmd)
        begin
            state_active <= (start_max != '0);
            cur_id       <= t_intr_id'(1);
            max_id       <= start_max;
        end
        else if (state_active)
        begin
            // Last id leaves this cycle when cur_id reaches max_id
            state_active <= (cur_id != max_id);
            cur_id       <= cur_id + t_intr_id'(1);
        end
    end

    assign intr_req_valid = start_cmd || state_active;
    assign intr_req_id    = start_cmd ? '0 : cur_id;

    // ==================================================
    // Response tracking
    // ==================================================

    // A new start clears the history, even over a response in the same cycle
    always_ff @(posedge clk)
    begin
        if (!reset_n || start_cmd)
        begin
            rsp_count <= '0;
            rsp_mask  <= '0;
        end
        else if (intr_rsp_valid)
        begin
            rsp_count             <= rsp_count + 8'd1;
            rsp_mask[intr_rsp_id] <= 1'b1;
        end
    end

    // ==================================================
    // Register values
    // ==================================================

    // Status mask field is always MAX_INTR_IDS wide
    always_comb
    begin
        status_mask                   = '0;
        status_mask[NUM_INTR_IDS-1:0] = rsp_mask;
    end

    always_comb
    begin
        // Unused registers read as zero
        for (int i = 0; i < NUM_CSRS; i++)
        begin
            csr.rd_data[i] = '0;
        end

        csr.rd_data[CSR_TEST_ID_LO] = TEST_ID[63:0];
        csr.rd_data[CSR_TEST_ID_HI] = TEST_ID[127:64];

        // Config has id count over engine count
        csr.rd_data[CSR_CONFIG] = {48'd0, 8'(NUM_INTR_IDS), CFG_NUM_ENGINES};

        // Status has the response mask over the response count
        csr.rd_data[CSR_STATUS] = {40'd0, status_mask, rsp_count};
    end

endmodule

//--- rtl/host_intr_shim.sv
// Adapter between the interrupt engine and the host write channel
// Each request becomes a registered host write whose address carries the
// interrupt index and whose user field carries the interrupt flag and a tag
// The tag returned with each response is decoded back into an index
module host_intr_shim
    import intr_test_pkg::*;
#(
    parameter  int NUM_INTR_IDS = 4,
    localparam int ID_W         = intr_id_width(NUM_INTR_IDS)
)
(
    input  logic            clk,
    input  logic            reset_n,

    // Requests from the engine
    input  logic            intr_req_valid,
    input  logic [ID_W-1:0] intr_req_id,

    // Host write channel
    output logic            host_wr_valid,
    output t_host_addr      host_wr_addr,
    output t_host_user      host_wr_user,

    // Host write responses
    input  logic            host_rsp_valid,
    input  t_host_user      host_rsp_user,

    // Decoded responses toward the engine
    output logic            intr_rsp_valid,
    output logic [ID_W-1:0] intr_rsp_id
);

    t_host_user req_user;

    // Interrupt flag plus the index as tag so out-of-order returns can be matched
    always_comb
    begin
        req_user                               = '0;
        req_user[HOST_UFLAG_INTERRUPT]         = 1'b1;
        req_user[HOST_UFLAG_TAG_LSB +: ID_W]   = intr_req_id;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            host_wr_valid <= 1'b0;
        end
        else
        begin
            host_wr_valid <= intr_req_valid;
        end
    end

    // The interrupt vector index goes out in the low address bits
    always_ff @(posedge clk)
    begin
        if (intr_req_valid)
        begin
            host_wr_addr <= t_host_addr'(intr_req_id);
            host_wr_user <= req_user;
        end
    end

    // Responses pass straight through so the engine counts them next cycle
    assign intr_rsp_valid = host_rsp_valid;
    assign intr_rsp_id    = host_rsp_user[HOST_UFLAG_TAG_LSB +: ID_W];

endmodule

//--- rtl/intr_test_afu.sv
// Top level of the interrupt test function
// Exposes the MMIO register channel and the host write channel as plain ports
// NUM_INTR_IDS sets how many interrupt indices exist, from 1 to MAX_INTR_IDS
module intr_test_afu
    import intr_test_pkg::*;
#(
    parameter int NUM_INTR_IDS = 4
)
(
    input  logic       clk,
    input  logic       reset_n,

    // MMIO write channel
    input  logic       mmio_wr_valid,
    input  t_mmio_addr mmio_wr_addr,
    input  t_csr_data  mmio_wr_data,

    // MMIO read channel
    input  logic       mmio_rd_valid,
    input  t_mmio_addr mmio_rd_addr,
    output logic       mmio_rd_data_valid,
    output t_csr_data  mmio_rd_data,

    // Host write channel
    output logic       host_wr_valid,
    output t_host_addr host_wr_addr,
    output t_host_user host_wr_user,

    // Host write responses
    input  logic       host_rsp_valid,
    input  t_host_user host_rsp_user
);

    localparam int ID_W = intr_id_width(NUM_INTR_IDS);

    // ==================================================
    // Internal connections
    // ==================================================

    engine_csr_if csr_if ();

    logic            intr_req_valid;
    logic [ID_W-1:0] intr_req_id;
    logic            intr_rsp_valid;
    logic [ID_W-1:0] intr_rsp_id;

    // ==================================================
    // Instances
    // ==================================================

    mmio_csr_mgr csr_mgr_i
    (
        .clk                (clk),
        .reset_n            (reset_n),
        .mmio_wr_valid      (mmio_wr_valid),
        .mmio_wr_addr       (mmio_wr_addr),
        .mmio_wr_data       (mmio_wr_data),
        .mmio_rd_valid      (mmio_rd_valid),
        .mmio_rd_addr       (mmio_rd_addr),
        .mmio_rd_data_valid (mmio_rd_data_valid),
        .mmio_rd_data       (mmio_rd_data),
        .csr                (csr_if.mgr)
    );

    intr_engine #(
        .NUM_INTR_IDS (NUM_INTR_IDS)
    ) intr_engine_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .csr            (csr_if.owner),
        .intr_req_valid (intr_req_valid),
        .intr_req_id    (intr_req_id),
        .intr_rsp_valid (intr_rsp_valid),
        .intr_rsp_id    (intr_rsp_id)
    );

    host_intr_shim #(
        .NUM_INTR_IDS (NUM_INTR_IDS)
    ) host_intr_shim_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .intr_req_valid (intr_req_valid),
        .intr_req_id    (intr_req_id),
        .host_wr_valid  (host_wr_valid),
        .host_wr_addr   (host_wr_addr),
        .host_wr_user   (host_wr_user),
        .host_rsp_valid (host_rsp_valid),
        .host_rsp_user  (host_rsp_user),
        .intr_rsp_valid (intr_rsp_valid),
        .intr_rsp_id    (intr_rsp_id)
    );

endmodule

//--- tests/intr_test_afu_tb.sv
// Testbench for the interrupt test function
// Drives MMIO reads and writes, models a host that returns interrupt writes
// after random delays and in random order, and checks the status register
// against a reference computed from the returned ids
// Runs standalone with intr_test_afu.f as the file list
module intr_test_afu_tb
    import intr_test_pkg::*;
();

    localparam int CLK_PERIOD      = 100;
    localparam int NUM_IDS         = 4;
    localparam int NUM_TESTS       = 5;
    localparam int WAIT_LIMIT      = 100;
    localparam int STATUS_MASK_LSB = 8;
    localparam logic [31:0] LFSR_SEED = 32'h75bc2362;

    logic       clk;
    logic       reset_n;
    logic       mmio_wr_valid;
    t_mmio_addr mmio_wr_addr;
    t_csr_data  mmio_wr_data;
    logic       mmio_rd_valid;
    t_mmio_addr mmio_rd_addr;
    logic       mmio_rd_data_valid;
    t_csr_data  mmio_rd_data;
    logic       host_wr_valid;
    t_host_addr host_wr_addr;
    t_host_user host_wr_user;
    logic       host_rsp_valid;
    t_host_user host_rsp_user;

    // Host model state shared with the main sequence
    int          expected_ids[$];
    t_host_user  pending_users[$];
    int          returned_ids[$];
    logic [15:0] hold_mask;
    logic [31:0] lfsr_state;
    string       test_name;
    int          mismatch_count;
    int          failure_count;

    intr_test_afu #(
        .NUM_INTR_IDS (NUM_IDS)
    ) intr_test_afu_i (
        .clk                (clk),
        .reset_n            (reset_n),
        .mmio_wr_valid      (mmio_wr_valid),
        .mmio_wr_addr       (mmio_wr_addr),
        .mmio_wr_data       (mmio_wr_data),
        .mmio_rd_valid      (mmio_rd_valid),
        .mmio_rd_addr       (mmio_rd_addr),
        .mmio_rd_data_valid (mmio_rd_data_valid),
        .mmio_rd_data       (mmio_rd_data),
        .host_wr_valid      (host_wr_valid),
        .host_wr_addr       (host_wr_addr),
        .host_wr_user       (host_wr_user),
        .host_rsp_valid     (host_rsp_valid),
        .host_rsp_user      (host_rsp_user)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==================================================
    // Reference model and checks
    // ==================================================

    // Galois LFSR, one step per random bit
    function automatic int take_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
            value      = (value << 1) | int'(lfsr_state[0]);
        end
        return value;
    endfunction

    // Status holds the response count in the low byte and one mask bit per id above
    function automatic t_csr_data expected_status(input int ids[$]);
        t_csr_data status;
        status = '0;
        foreach (ids[i])
        begin
            status = status | (t_csr_data'(1) << (STATUS_MASK_LSB + ids[i]));
        end
        status[7:0] = 8'(ids.size());
        return status;
    endfunction

    function automatic int tag_of(input t_host_user user);
        return int'(user[HOST_UFLAG_TAG_LSB +: 8]);
    endfunction

    function automatic logic is_held(input int id);
        return hold_mask[id[3:0]];
    endfunction

    // Pending writes the host is allowed to answer right now
    function automatic int returnable_count();
        int n;
        n = 0;
        foreach (pending_users[i])
        begin
            if (!is_held(tag_of(pending_users[i])))
                n++;
        end
        return n;
    endfunction

    task automatic check_csr(input string name, input t_csr_data exp, input t_csr_data act);
        if (act !== exp)
        begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_addr(input string name, input t_host_addr exp, input t_host_addr act);
        if (act !== exp)
        begin
            $display("MISMATCH %s: host address expected %h, actual %h", name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_user(input string name, input t_host_user exp, input t_host_user act);
        if (act !== exp)
        begin
            $display("MISMATCH %s: host user expected %h, actual %h", name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("ERROR %s: %s", test_name, what);
        failure_count++;
    endtask

    // ==================================================
    // Host model
    // ==================================================

    // Checks every interrupt write against the expected id order, then answers
    // pending writes one at a time after random gaps and in random order
    initial
    begin
        int         ready_idx[$];
        int         pick;
        int         exp_id;
        t_host_user exp_user;

        lfsr_state     = LFSR_SEED;
        host_rsp_valid = 1'b0;
        host_rsp_user  = '0;
        forever
        begin
            @(negedge clk);
            host_rsp_valid = 1'b0;
            ready_idx.delete();
            foreach (pending_users[i])
            begin
                if (!is_held(tag_of(pending_users[i])))
                    ready_idx.push_back(i);
            end
            // Roughly one chance in four per cycle to answer
            if (ready_idx.size() > 0 && take_bits(2) == 0)
            begin
                pick           = ready_idx[take_bits(4) % ready_idx.size()];
                host_rsp_valid = 1'b1;
                host_rsp_user  = pending_users[pick];
                returned_ids.push_back(tag_of(pending_users[pick]));
                pending_users.delete(pick);
            end

            // New writes are collected after the answer so none returns at once
            if (host_wr_valid)
            begin
                if (expected_ids.size() == 0)
                begin
                    report_failure("host write arrived when none was expected");
                end
                else
                begin
                    exp_id   = expected_ids.pop_front();
                    exp_user = t_host_user'(1 << HOST_UFLAG_INTERRUPT)
                             | (t_host_user'(exp_id) << HOST_UFLAG_TAG_LSB);
                    check_addr(test_name, t_host_addr'(exp_id), host_wr_addr);
                    check_user(test_name, exp_user, host_wr_user);
                end
                pending_users.push_back(host_wr_user);
            end
        end
    end

    // ==================================================
    // MMIO access and sequencing tasks
    // ==================================================

    // Strobe goes out in the cycle after the current falling edge
    task automatic mmio_write(input t_csr_idx idx, input t_csr_data data);
        mmio_wr_valid = 1'b1;
        mmio_wr_addr  = t_mmio_addr'(idx) * 16'd8;
        mmio_wr_data  = data;
        @(negedge clk);
        mmio_wr_valid = 1'b0;
    endtask

    task automatic mmio_read(input t_csr_idx idx, output t_csr_data data);
        int cycles;
        mmio_rd_valid = 1'b1;
        mmio_rd_addr  = t_mmio_addr'(idx) * 16'd8;
        @(negedge clk);
        mmio_rd_valid = 1'b0;
        cycles = 0;
        while (!mmio_rd_data_valid && cycles < WAIT_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!mmio_rd_data_valid)
            report_failure($sformatf("no read response for register %0d", idx));
        data = mmio_rd_data;
    endtask

    task automatic read_check(input string name, input t_csr_idx idx, input t_csr_data exp);
        t_csr_data data;
        mmio_read(idx, data);
        check_csr(name, exp, data);
    endtask

    // Starts a sequence and checks that the first write comes two cycles later
    task automatic start_sequence(input t_csr_data data);
        int max_id;
        max_id = int'(data % 64'(NUM_IDS));
        returned_ids.delete();
        for (int i = 0; i <= max_id; i++)
        begin
            expected_ids.push_back(i);
        end
        mmio_write(CSR_START, data);
        if (host_wr_valid)
            report_failure("host write came one cycle after the start write");
        @(negedge clk);
        if (!host_wr_valid)
            report_failure("first host write did not come two cycles after the start write");
    endtask

    task automatic wait_writes_done();
        int cycles;
        cycles = 0;
        while (expected_ids.size() != 0 && cycles < WAIT_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (expected_ids.size() != 0)
            report_failure($sformatf("%0d host writes never arrived", expected_ids.size()));
        expected_ids.delete();
        // Quiet window in which an extra write would be flagged
        repeat (4) @(negedge clk);
    endtask

    // One more cycle after the last answer so the status already counts it
    task automatic wait_host_idle();
        int cycles;
        cycles = 0;
        while (returnable_count() != 0 && cycles < WAIT_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (returnable_count() != 0)
            report_failure("host model did not return its pending writes");
        @(negedge clk);
    endtask

    // ==================================================
    // Test sequence
    // ==================================================

    initial
    begin
        reset_n        = 1'b0;
        mmio_wr_valid  = 1'b0;
        mmio_wr_addr   = '0;
        mmio_wr_data   = '0;
        mmio_rd_valid  = 1'b0;
        mmio_rd_addr   = '0;
        hold_mask      = '0;
        mismatch_count = 0;
        failure_count  = 0;
        test_name      = "reset_state";
        repeat (4) @(negedge clk);
        reset_n = 1'b1;

        repeat (10)
        begin
            @(negedge clk);
            if (host_wr_valid)
                report_failure("host write seen after reset");
        end
        read_check("reset_state", CSR_TEST_ID_LO, TEST_ID[63:0]);
        read_check("reset_state", CSR_TEST_ID_HI, TEST_ID[127:64]);
        read_check("reset_state", CSR_CONFIG, (t_csr_data'(NUM_IDS) << 8) | t_csr_data'(1));
        read_check("reset_state", CSR_STATUS, '0);
        read_check("reset_state", 3'd5, '0);

        test_name = "issue_sequence";
        start_sequence(64'd3);
        wait_writes_done();
        wait_host_idle();

        // A maximum of 6 folds to 2 with four ids
        test_name = "all_returned";
        start_sequence(64'd6);
        wait_writes_done();
        wait_host_idle();
        read_check("all_returned", CSR_STATUS, expected_status(returned_ids));

        // Ids 0 and 2 stay with the host until released
        test_name = "partial_return";
        hold_mask = 16'b0101;
        start_sequence(64'd3);
        wait_writes_done();
        wait_host_idle();
        read_check("partial_return", CSR_STATUS, expected_status(returned_ids));
        hold_mask = '0;
        wait_host_idle();
        read_check("partial_return", CSR_STATUS, expected_status(returned_ids));

        // Second start one cycle after the first takes over from id 0
        test_name = "restart";
        hold_mask = '1;
        returned_ids.delete();
        expected_ids.push_back(0);
        expected_ids.push_back(0);
        expected_ids.push_back(1);
        mmio_write(CSR_START, 64'd3);
        mmio_write(CSR_START, 64'd1);
        wait_writes_done();
        wait_host_idle();
        read_check("restart", CSR_STATUS, expected_status(returned_ids));
        hold_mask = '0;
        wait_host_idle();
        read_check("restart", CSR_STATUS, expected_status(returned_ids));

        $display("Checks done: %0d mismatches, %0d other errors", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // Budget of 200 cycles per test
    initial
    begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", NUM_TESTS * 200);
        $display("Test failures found");
        $finish;
    end

endmodule

//--- intr_test_afu.f
rtl/intr_test_pkg.sv
rtl/engine_csr_if.sv
rtl/mmio_csr_mgr.sv
rtl/intr_engine.sv
rtl/host_intr_shim.sv
rtl/intr_test_afu.sv
tests/intr_test_afu_tb.sv

//--- Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing -j 0
TOP       := intr_test_afu_tb
FILELIST  := intr_test_afu.f
BUILD_DIR := obj_dir
PASS_MSG  := All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The run fails unless the pass message appears in the simulation output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
